/* logic/dbg_pkg.sv */
package dbg_pkg;

    typedef logic [7:0]  byte_t;    // One link byte
    typedef logic [31:0] word_t;    // Core word and address
    typedef logic [4:0]  reg_sel_t; // Register file index

    localparam int NUM_REGS       = 32;                 // Registers in a dump
    localparam int DATA_MEM_BYTES = 256;                // Data memory bytes in a dump
    localparam int MEM_WORDS      = DATA_MEM_BYTES / 4; // Data memory words in a dump

    // Command characters from the link
    localparam byte_t CMD_RUN  = 8'h72; // 'r'
    localparam byte_t CMD_STEP = 8'h73; // 's'
    localparam byte_t CMD_LOAD = 8'h6c; // 'l'
    localparam byte_t CMD_NEXT = 8'h6e; // 'n'

    localparam word_t LOAD_END_WORD = 32'hffff_ffff; // Last word of a program load

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_STEP_WAIT,
        CTRL_STEP_PULSE,
        CTRL_DUMPING,
        CTRL_LOADING
    } ctrl_state_t;

    typedef enum logic [2:0] {
        DUMP_IDLE,
        DUMP_ADDR,
        DUMP_CAPTURE,
        DUMP_SEND,
        DUMP_DONE
    } dump_state_t;

endpackage

/* logic/rx_handshake.sv */
`timescale 1ns/1ps

module rx_handshake (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_req,
    input  dbg_pkg::byte_t i_data,
    input  logic           i_hold,
    output logic           o_ack,
    output logic           o_strobe,
    output dbg_pkg::byte_t o_byte
);
    import dbg_pkg::*;

    logic  ack_q;
    logic  strobe_q;
    byte_t byte_q;
    logic  accept;

    // New request, previous one fully released, and no dump in progress
    assign accept = i_req && !ack_q && !i_hold;

    always_ff @(posedge i_clk) begin
        if (accept) begin
            byte_q <= i_data; // Data is stable while req is high
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q    <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= accept;     // One pulse per request
            if (accept) begin
                ack_q <= 1'b1;
            end else if (ack_q && !i_req) begin
                ack_q <= 1'b0;      // Requester let go
            end
        end
    end

    assign o_ack    = ack_q;
    assign o_strobe = strobe_q;
    assign o_byte   = byte_q;

endmodule

/* logic/debug_controller.sv */
`timescale 1ns/1ps

module debug_controller (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_strobe,
    input  dbg_pkg::byte_t i_byte,
    input  logic           i_cpu_halt,
    input  logic           i_load_done,
    input  logic           i_dump_done,
    output logic           o_load_active,
    output logic           o_dump_start,
    output logic           o_hold,
    output logic           o_cpu_rst,
    output logic           o_cpu_clk_en
);
    import dbg_pkg::*;

    ctrl_state_t state_q;
    logic        step_mode_q;  // Return to step_wait after a dump
    logic        cpu_rst_q;
    logic        clk_en_q;
    logic        dump_start_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q      <= CTRL_IDLE;
            step_mode_q  <= 1'b0;
            cpu_rst_q    <= 1'b1;
            clk_en_q     <= 1'b0;
            dump_start_q <= 1'b0;
        end else begin
            dump_start_q <= 1'b0;
            case (state_q)
                CTRL_IDLE: begin
                    if (i_strobe) begin
                        case (i_byte)
                            CMD_RUN: begin
                                cpu_rst_q   <= 1'b0;
                                clk_en_q    <= 1'b1;   // Free running until halt
                                step_mode_q <= 1'b0;
                                state_q     <= CTRL_RUN;
                            end
                            CMD_STEP: begin
                                cpu_rst_q   <= 1'b0;
                                step_mode_q <= 1'b1;
                                state_q     <= CTRL_STEP_WAIT;
                            end
                            CMD_LOAD: begin
                                state_q <= CTRL_LOADING;
                            end
                            default: begin
                                state_q <= CTRL_IDLE; // Unknown character dropped
                            end
                        endcase
                    end
                end
                CTRL_RUN: begin
                    if (i_cpu_halt) begin
                        clk_en_q     <= 1'b0;
                        dump_start_q <= 1'b1;
                        state_q      <= CTRL_DUMPING;
                    end
                end
                CTRL_STEP_WAIT: begin
                    if (i_cpu_halt) begin
                        step_mode_q  <= 1'b0;    // Final dump, then idle
                        dump_start_q <= 1'b1;
                        state_q      <= CTRL_DUMPING;
                    end else if (i_strobe && i_byte == CMD_NEXT) begin
                        clk_en_q <= 1'b1;        // Exactly one core cycle
                        state_q  <= CTRL_STEP_PULSE;
                    end
                end
                CTRL_STEP_PULSE: begin
                    clk_en_q     <= 1'b0;
                    dump_start_q <= 1'b1;
                    state_q      <= CTRL_DUMPING;
                end
                CTRL_DUMPING: begin
                    if (i_dump_done) begin
                        if (step_mode_q) begin
                            state_q <= CTRL_STEP_WAIT;
                        end else begin
                            cpu_rst_q <= 1'b1;   // Core parked until next command
                            state_q   <= CTRL_IDLE;
                        end
                    end
                end
                CTRL_LOADING: begin
                    if (i_load_done) begin
                        state_q <= CTRL_IDLE;
                    end
                end
                default: begin
                    state_q <= CTRL_IDLE;
                end
            endcase
        end
    end

    assign o_load_active = (state_q == CTRL_LOADING);  // Route bytes to the loader
    assign o_hold        = (state_q == CTRL_STEP_PULSE) || (state_q == CTRL_DUMPING);
    assign o_dump_start  = dump_start_q;
    assign o_cpu_rst     = cpu_rst_q;
    assign o_cpu_clk_en  = clk_en_q;

endmodule

/* logic/instr_loader.sv */
`timescale 1ns/1ps

module instr_loader (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_active,
    input  logic           i_strobe,
    input  dbg_pkg::byte_t i_byte,
    output logic           o_done,
    output dbg_pkg::word_t o_instr_addr,
    output dbg_pkg::word_t o_instr_data,
    output logic           o_instr_we
);
    import dbg_pkg::*;

    logic [1:0] byte_cnt_q;  // Bytes gathered in the current word
    word_t      word_q;
    word_t      word_next;
    word_t      addr_q;
    logic       we_q;
    logic       done_q;
    logic       take;

    assign take      = i_active && i_strobe;
    assign word_next = {word_q[23:0], i_byte}; // Most significant byte arrives first

    always_ff @(posedge i_clk) begin
        if (take) begin
            word_q <= word_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            byte_cnt_q <= 2'd0;
            addr_q     <= '0;
            we_q       <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            we_q   <= 1'b0;
            done_q <= 1'b0;
            if (we_q) begin
                addr_q <= done_q ? word_t'(0) : addr_q + 32'd4; // Next load starts at 0
            end
            if (take) begin
                byte_cnt_q <= byte_cnt_q + 2'd1;
                if (byte_cnt_q == 2'd3) begin
                    we_q   <= 1'b1;
                    done_q <= (word_next == LOAD_END_WORD);
                end
            end
        end
    end

    assign o_done       = done_q;
    assign o_instr_addr = addr_q;
    assign o_instr_data = word_q;
    assign o_instr_we   = we_q;

endmodule

/* logic/dump_sequencer.sv */
`timescale 1ns/1ps

module dump_sequencer (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  dbg_pkg::word_t    i_cpu_pc,
    input  dbg_pkg::word_t    i_cpu_cycles,
    input  dbg_pkg::word_t    i_reg_data,
    input  dbg_pkg::word_t    i_mem_data,
    output dbg_pkg::reg_sel_t o_reg_sel,
    output dbg_pkg::word_t    o_mem_addr,
    output logic              o_word_req,
    output dbg_pkg::word_t    o_word_data,
    input  logic              i_word_ack,
    output logic              o_done
);
    import dbg_pkg::*;

    dump_state_t state_q;
    logic [1:0]  phase_q;  // 0 pc, 1 cycles, 2 registers, 3 data memory
    logic [5:0]  idx_q;    // Register or memory word index
    word_t       hold_q;
    logic        req_q;
    logic        done_q;

    always_ff @(posedge i_clk) begin
        if (state_q == DUMP_CAPTURE) begin
            case (phase_q)
                2'd0:    hold_q <= i_cpu_pc;
                2'd1:    hold_q <= i_cpu_cycles;
                2'd2:    hold_q <= i_reg_data;
                default: hold_q <= i_mem_data;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= DUMP_IDLE;
            phase_q <= 2'd0;
            idx_q   <= 6'd0;
            req_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                DUMP_IDLE: begin
                    if (i_start) begin
                        phase_q <= 2'd0;
                        idx_q   <= 6'd0;
                        state_q <= DUMP_ADDR;
                    end
                end
                DUMP_ADDR: begin
                    if (!i_word_ack) begin
                        state_q <= DUMP_CAPTURE; // Previous word handshake closed
                    end
                end
                DUMP_CAPTURE: begin
                    req_q   <= 1'b1;
                    state_q <= DUMP_SEND;
                end
                DUMP_SEND: begin
                    if (i_word_ack) begin
                        req_q   <= 1'b0;
                        state_q <= DUMP_ADDR;
                        case (phase_q)
                            2'd2: begin
                                if (idx_q == 6'(NUM_REGS - 1)) begin
                                    phase_q <= 2'd3;
                                    idx_q   <= 6'd0;
                                end else begin
                                    idx_q <= idx_q + 6'd1;
                                end
                            end
                            2'd3: begin
                                if (idx_q == 6'(MEM_WORDS - 1)) begin
                                    state_q <= DUMP_DONE;
                                end else begin
                                    idx_q <= idx_q + 6'd1;
                                end
                            end
                            default: phase_q <= phase_q + 2'd1; // Pc, then cycle count
                        endcase
                    end
                end
                DUMP_DONE: begin
                    if (!i_word_ack) begin
                        done_q  <= 1'b1;
                        state_q <= DUMP_IDLE;
                    end
                end
                default: begin
                    state_q <= DUMP_IDLE;
                end
            endcase
        end
    end

    assign o_reg_sel   = idx_q[4:0];
    assign o_mem_addr  = {24'd0, idx_q, 2'b00};  // Word aligned byte address
    assign o_word_req  = req_q;
    assign o_word_data = hold_q;
    assign o_done      = done_q;

endmodule

/* logic/word_serializer.sv */
`timescale 1ns/1ps

module word_serializer (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_word_req,
    input  dbg_pkg::word_t i_word_data,
    output logic           o_word_ack,
    output logic           o_tx_req,
    output dbg_pkg::byte_t o_tx_data,
    input  logic           i_tx_ack
);
    import dbg_pkg::*;

    word_t      shift_q;
    logic [1:0] byte_cnt_q;  // Byte being sent
    logic       busy_q;
    logic       tx_req_q;
    logic       word_ack_q;
    logic       load_word;
    logic       byte_done;

    // Start only once both handshakes are fully released
    assign load_word = !busy_q && !word_ack_q && i_word_req && !i_tx_ack;
    assign byte_done = busy_q && !tx_req_q && !i_tx_ack; // Byte handshake complete

    always_ff @(posedge i_clk) begin
        if (load_word) begin
            shift_q <= i_word_data;
        end else if (byte_done && byte_cnt_q != 2'd3) begin
            shift_q <= {shift_q[23:0], 8'h00};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            byte_cnt_q <= 2'd0;
            busy_q     <= 1'b0;
            tx_req_q   <= 1'b0;
            word_ack_q <= 1'b0;
        end else begin
            if (load_word) begin
                busy_q     <= 1'b1;
                byte_cnt_q <= 2'd0;
                tx_req_q   <= 1'b1;
            end else if (tx_req_q && i_tx_ack) begin
                tx_req_q <= 1'b0;
            end else if (byte_done) begin
                if (byte_cnt_q == 2'd3) begin
                    busy_q     <= 1'b0;
                    word_ack_q <= 1'b1;   // Whole word is out
                end else begin
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                    tx_req_q   <= 1'b1;
                end
            end
            if (word_ack_q && !i_word_req) begin
                word_ack_q <= 1'b0;
            end
        end
    end

    assign o_word_ack = word_ack_q;
    assign o_tx_req   = tx_req_q;
    assign o_tx_data  = shift_q[31:24];  // Most significant byte first

endmodule

/* logic/debug_top.sv */
`timescale 1ns/1ps

module debug_top (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_rx_req,
    input  dbg_pkg::byte_t    i_rx_data,
    output logic              o_rx_ack,
    output logic              o_tx_req,
    output dbg_pkg::byte_t    o_tx_data,
    input  logic              i_tx_ack,
    output logic              o_cpu_rst,
    output logic              o_cpu_clk_en,
    input  logic              i_cpu_halt,
    input  dbg_pkg::word_t    i_cpu_pc,
    input  dbg_pkg::word_t    i_cpu_cycles,
    output dbg_pkg::reg_sel_t o_reg_sel,
    input  dbg_pkg::word_t    i_reg_data,
    output dbg_pkg::word_t    o_mem_addr,
    input  dbg_pkg::word_t    i_mem_data,
    output dbg_pkg::word_t    o_instr_addr,
    output dbg_pkg::word_t    o_instr_data,
    output logic              o_instr_we
);
    import dbg_pkg::*;

    logic  rx_strobe;
    byte_t rx_byte;
    logic  hold;
    logic  load_active;
    logic  load_done;
    logic  dump_start;
    logic  dump_done;
    logic  word_req;
    word_t word_data;
    logic  word_ack;

    rx_handshake u_rx (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_req(i_rx_req), .i_data(i_rx_data), .i_hold(hold),
        .o_ack(o_rx_ack), .o_strobe(rx_strobe), .o_byte(rx_byte)
    );

    debug_controller u_ctrl (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_strobe(rx_strobe), .i_byte(rx_byte), .i_cpu_halt(i_cpu_halt),
        .i_load_done(load_done), .i_dump_done(dump_done),
        .o_load_active(load_active), .o_dump_start(dump_start), .o_hold(hold),
        .o_cpu_rst(o_cpu_rst), .o_cpu_clk_en(o_cpu_clk_en)
    );

    instr_loader u_loader (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_active(load_active), .i_strobe(rx_strobe), .i_byte(rx_byte),
        .o_done(load_done), .o_instr_addr(o_instr_addr),
        .o_instr_data(o_instr_data), .o_instr_we(o_instr_we)
    );

    dump_sequencer u_dump (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(dump_start),
        .i_cpu_pc(i_cpu_pc), .i_cpu_cycles(i_cpu_cycles),
        .i_reg_data(i_reg_data), .i_mem_data(i_mem_data),
        .o_reg_sel(o_reg_sel), .o_mem_addr(o_mem_addr),
        .o_word_req(word_req), .o_word_data(word_data), .i_word_ack(word_ack),
        .o_done(dump_done)
    );

    word_serializer u_ser (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_word_req(word_req), .i_word_data(word_data), .o_word_ack(word_ack),
        .o_tx_req(o_tx_req), .o_tx_data(o_tx_data), .i_tx_ack(i_tx_ack)
    );

endmodule

/* dv/debug_top_assert.sv */
`timescale 1ns/1ps

module dbg_handshake_assert (
    input logic           i_clk,
    input logic           i_rst,
    input logic           i_tx_req,
    input dbg_pkg::byte_t i_tx_data,
    input logic           i_tx_ack,
    input logic           i_cpu_rst,
    input logic           i_cpu_clk_en,
    input logic           i_instr_we
);

    tx_data_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_req && $past(i_tx_req) |-> $stable(i_tx_data))
        else $error("transmit data changed while the request was high");

    tx_req_after_ack_low: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_tx_req) |-> !$past(i_tx_ack))
        else $error("transmit request raised while the acknowledge was still high");

    clk_en_in_reset: assert property (@(posedge i_clk) disable iff (i_rst)
        i_cpu_rst |-> !i_cpu_clk_en)
        else $error("core clock enable high while the core is held in reset");

    instr_we_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_instr_we |=> !i_instr_we)
        else $error("instruction write lasted more than one cycle");

    // First sample after reset release
    reset_values: assert property (@(posedge i_clk)
        $fell(i_rst) |-> i_cpu_rst && !i_cpu_clk_en && !i_tx_req && !i_instr_we)
        else $error("outputs not at their reset values after reset");

endmodule

bind debug_top dbg_handshake_assert u_assert (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_tx_req(o_tx_req), .i_tx_data(o_tx_data), .i_tx_ack(i_tx_ack),
    .i_cpu_rst(o_cpu_rst), .i_cpu_clk_en(o_cpu_clk_en), .i_instr_we(o_instr_we)
);

/* dv/tb_debug_top.sv */
`timescale 1ns/1ps

module tb_debug_top;
    import dbg_pkg::*;

    localparam int MAX_DELAY   = 3;   // Link response delay in cycles
    localparam int LOAD_WORDS  = 6;   // Program words before the end word
    localparam int UNKNOWN_CNT = 8;
    localparam int MAX_RUN     = 40;
    localparam int MAX_STEPS   = 4;
    localparam int DUMP_BYTES  = 4 * (2 + NUM_REGS + MEM_WORDS);
    localparam int SENT_BYTES  = 2 * (1 + 4 * (LOAD_WORDS + 1)) + UNKNOWN_CNT + 2 + MAX_STEPS;
    localparam int HS_CYCLES   = 2 * MAX_DELAY + 8;  // Worst case per byte on either link
    localparam int TIMEOUT     = (SENT_BYTES + DUMP_BYTES * (MAX_STEPS + 2)) * HS_CYCLES
                                 + MAX_RUN + 500;

    logic     i_clk;
    logic     i_rst;
    logic     i_rx_req;
    byte_t    i_rx_data;
    logic     o_rx_ack;
    logic     o_tx_req;
    byte_t    o_tx_data;
    logic     i_tx_ack;
    logic     o_cpu_rst;
    logic     o_cpu_clk_en;
    logic     i_cpu_halt;
    word_t    i_cpu_pc;
    word_t    i_cpu_cycles;
    reg_sel_t o_reg_sel;
    word_t    i_reg_data;
    word_t    o_mem_addr;
    word_t    i_mem_data;
    word_t    o_instr_addr;
    word_t    o_instr_data;
    logic     o_instr_we;

    word_t regs [NUM_REGS];
    word_t mem  [MEM_WORDS];
    word_t cycles;
    word_t halt_limit;
    byte_t exp_bytes [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    cycle_cnt = 0;

    debug_top uut (.*);

    assign i_cpu_cycles = cycles;
    assign i_cpu_pc     = cycles << 2;              // One instruction per cycle
    assign i_cpu_halt   = (cycles >= halt_limit);
    assign i_reg_data   = regs[o_reg_sel];
    assign i_mem_data   = mem[o_mem_addr[7:2]];

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_byte(input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch o_tx_data got 0x%02h expected 0x%02h",
                               actual, expected));
        end
    endtask

    task automatic check_write(input word_t addr, input word_t data,
                               input word_t exp_a, input word_t exp_d);
        if (addr !== exp_a) begin
            fail_run($sformatf("mismatch o_instr_addr got 0x%08h expected 0x%08h", addr, exp_a));
        end else if (data !== exp_d) begin
            fail_run($sformatf("mismatch o_instr_data got 0x%08h expected 0x%08h", data, exp_d));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic push_word(input word_t w);
        for (int b = 3; b >= 0; b--) begin
            exp_bytes.push_back(w[8*b +: 8]);   // Most significant byte first
        end
    endtask

    task automatic push_dump(input word_t count);
        push_word(count << 2);
        push_word(count);
        foreach (regs[i]) push_word(regs[i]);
        foreach (mem[i]) push_word(mem[i]);
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge i_clk);
        #1;
        i_rx_data = b;
        i_rx_req  = 1'b1;
        do @(posedge i_clk); while (o_rx_ack !== 1'b1);
        repeat ($urandom_range(0, MAX_DELAY)) @(posedge i_clk);
        #1;
        i_rx_req = 1'b0;
        do @(posedge i_clk); while (o_rx_ack !== 1'b0);
    endtask

    task automatic load_program(input int n);
        word_t w;
        send_byte(CMD_LOAD);
        for (int i = 0; i <= n; i++) begin
            w = (i == n) ? LOAD_END_WORD : word_t'($urandom);
            if (i != n && w == LOAD_END_WORD) begin
                w = 32'h0;   // End marker only as the last word
            end
            exp_addr.push_back(word_t'(4 * i));
            exp_data.push_back(w);
            for (int b = 3; b >= 0; b--) begin
                send_byte(w[8*b +: 8]);
            end
        end
        while (exp_addr.size() != 0) @(posedge i_clk);
    endtask

    task automatic wait_drained();
        while (exp_bytes.size() != 0) @(posedge i_clk);
    endtask

    task automatic wait_idle();
        while (o_cpu_rst !== 1'b1) @(posedge i_clk);
        #1;
    endtask

    // Core model that counts enabled cycles and clears while held in reset
    always @(posedge i_clk) begin : core_model
        logic rst_seen;
        logic en_seen;
        rst_seen = o_cpu_rst;
        en_seen  = o_cpu_clk_en;
        #1;
        if (rst_seen === 1'b1) begin
            cycles = '0;
        end else if (en_seen === 1'b1) begin
            cycles = cycles + 32'd1;
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_instr_we === 1'b1) begin
            if (exp_addr.size() == 0) begin
                fail_run("instruction write while no load was in progress");
            end else begin
                check_write(o_instr_addr, o_instr_data, exp_addr.pop_front(), exp_data.pop_front());
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            fail_run($sformatf("timeout after %0d cycles, the DUT stopped responding", TIMEOUT));
        end
    end

    // Transmit link responder with random delays on both edges of ack
    initial begin : tx_responder
        forever begin
            @(posedge i_clk);
            if (o_tx_req === 1'b1 && i_tx_ack === 1'b0) begin
                repeat ($urandom_range(0, MAX_DELAY)) @(posedge i_clk);
                #1;
                if (exp_bytes.size() == 0) begin
                    fail_run("transmit byte sent while no dump was expected");
                end else begin
                    check_byte(o_tx_data, exp_bytes.pop_front());
                end
                i_tx_ack = 1'b1;
                do @(posedge i_clk); while (o_tx_req !== 1'b0);
                repeat ($urandom_range(0, MAX_DELAY)) @(posedge i_clk);
                #1;
                i_tx_ack = 1'b0;
            end
        end
    end

    initial begin : main
        byte_t c;
        void'($urandom(35170));
        i_rst      = 1'b1;
        i_rx_req   = 1'b0;
        i_rx_data  = 8'h00;
        i_tx_ack   = 1'b0;
        cycles     = '0;
        halt_limit = 32'd1;
        foreach (regs[i]) regs[i] = $urandom;
        foreach (mem[i]) mem[i] = $urandom;
        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        repeat (8) @(posedge i_clk);
        check_flag("o_cpu_rst", o_cpu_rst, 1'b1);
        check_flag("o_cpu_clk_en", o_cpu_clk_en, 1'b0);

        load_program(LOAD_WORDS);
        load_program(LOAD_WORDS);   // Restarts at address 0

        for (int i = 0; i < UNKNOWN_CNT; i++) begin
            do begin
                c = byte_t'($urandom_range(0, 255));
            end while (c == CMD_RUN || c == CMD_STEP || c == CMD_LOAD);
            send_byte(c);
        end
        repeat (4) @(posedge i_clk);
        check_flag("o_cpu_rst", o_cpu_rst, 1'b1);
        check_flag("o_cpu_clk_en", o_cpu_clk_en, 1'b0);

        // Clock enable also covers the cycle in which halt is seen
        halt_limit = word_t'($urandom_range(5, MAX_RUN));
        push_dump(halt_limit + 32'd1);
        send_byte(CMD_RUN);
        wait_drained();
        wait_idle();

        halt_limit = word_t'($urandom_range(2, MAX_STEPS));
        send_byte(CMD_STEP);
        for (int k = 1; k <= int'(halt_limit); k++) begin
            push_dump(word_t'(k));
            if (k == int'(halt_limit)) begin
                push_dump(word_t'(k));  // Halt in step_wait adds a final dump
            end
            send_byte(CMD_NEXT);
            wait_drained();
        end
        wait_idle();
        check_flag("o_cpu_clk_en", o_cpu_clk_en, 1'b0);

        repeat (4) @(posedge i_clk);
        $display("Regression passed");
        $finish;
    end

endmodule

/* verilog.f */
logic/dbg_pkg.sv
logic/rx_handshake.sv
logic/debug_controller.sv
logic/instr_loader.sv
logic/dump_sequencer.sv
logic/word_serializer.sv
logic/debug_top.sv
dv/debug_top_assert.sv
dv/tb_debug_top.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_debug_top \
    -Mdir obj_dir \
    -f verilog.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vtb_debug_top
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0
